//--- hdl/audio_pkg.sv
/*
 * Shared definitions for the I2S audio output path: sample, volume and
 * FIFO widths, clock divider tap positions, frame structs and the
 * serializer state encoding
 */
`default_nettype none

package audio_pkg;

    // Audio sample and attenuation code
    localparam int SAMPLE_W = 16;  // Signed PCM sample width
    localparam int VOL_W    = 3;   // Attenuation code width

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic        [VOL_W-1:0]    volume_t;

    localparam volume_t VOL_MUTE = 3'd7;  // Highest code silences the channel

    // Frame as delivered by the sample source
    typedef struct packed {
        volume_t volume;  // Attenuation applied to both channels
        sample_t left;
        sample_t right;
    } audio_in_t;

    // Scaled frame as stored in the FIFO
    typedef struct packed {
        sample_t left;
        sample_t right;
    } stereo_frame_t;

    // Frame FIFO geometry, the count needs one bit more than a pointer
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = 2;
    localparam int FIFO_CNT_W = FIFO_PTR_W + 1;

    typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
    typedef logic [FIFO_CNT_W-1:0] fifo_count_t;

    // I2S slot layout, each channel gets a 32 bit slot with the sample left justified
    localparam int SLOT_BITS  = 32;
    localparam int SLOT_PAD_W = SLOT_BITS - SAMPLE_W;  // Zero bits after the LSB
    localparam int FRAME_BITS = 2 * SLOT_BITS;

    typedef logic [FRAME_BITS-1:0] frame_shift_t;

    // Clock divider taps keep mclk:bclk:lrclk at 256:64:1
    localparam int DIV_W     = 9;
    localparam int MCLK_BIT  = 0;  // clk/2
    localparam int BCLK_BIT  = 2;  // clk/8
    localparam int LRCLK_BIT = 8;  // clk/512

    typedef logic [DIV_W-1:0] clk_div_t;

    // Serializer phases
    typedef enum logic [1:0] {
        ST_IDLE,   // After reset, waiting for the first load point
        ST_LOAD,   // Divider at all ones, frame enters the shift register
        ST_SHIFT   // Bits go out on bclk falling positions
    } serializer_state_t;

endpackage

`default_nettype wire

//--- hdl/volume_scaler.sv
/*
 * Volume scaler, the producer stage: one register stage that
 * attenuates both channels of a frame and pushes it into the FIFO
 */
`timescale 1ns/1ps
`default_nettype none

module volume_scaler
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      in_valid,    // One frame per cycle while credits last
    input  audio_pkg::audio_in_t      in_frame,
    output logic                      push,        // Registered copy of in_valid
    output audio_pkg::stereo_frame_t  push_frame
);

    // Arithmetic right shift by the code, the top code mutes outright
    function automatic audio_pkg::sample_t attenuate
    (
        input audio_pkg::sample_t sample,
        input audio_pkg::volume_t volume
    );
        if (volume == audio_pkg::VOL_MUTE)
        begin
            return '0;
        end
        return sample >>> volume;  // Sign is kept, so negative samples round toward minus infinity
    endfunction

    audio_pkg::stereo_frame_t scaled;  // Combinational result for the incoming frame

    always_comb
    begin
        scaled.left  = attenuate(in_frame.left,  in_frame.volume);
        scaled.right = attenuate(in_frame.right, in_frame.volume);
    end

    // Push strobe, exactly one cycle behind in_valid
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            push <= 1'b0;
        end
        else
        begin
            push <= in_valid;
        end
    end

    // Payload only moves when a frame arrives
    always_ff @(posedge clk)
    begin
        if (in_valid)
        begin
            push_frame <= scaled;  // No stall path, the credits guarantee FIFO space
        end
    end

endmodule

`default_nettype wire

//--- hdl/sample_fifo.sv
/*
 * Frame FIFO with first-word fall-through: circular buffer with read
 * and write pointers, an occupancy count and a credit pulse per pop
 */
`timescale 1ns/1ps
`default_nettype none

module sample_fifo
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      push,        // Never seen while full under the credit rule
    input  audio_pkg::stereo_frame_t  push_frame,
    input  logic                      pop,         // Only issued while not empty
    output audio_pkg::stereo_frame_t  head_frame,  // Oldest entry, valid whenever empty is low
    output logic                      empty,
    output logic                      credit       // One cycle after each pop
);

    audio_pkg::stereo_frame_t mem [audio_pkg::FIFO_DEPTH];

    audio_pkg::fifo_ptr_t   wr_ptr;
    audio_pkg::fifo_ptr_t   rd_ptr;
    audio_pkg::fifo_count_t count;

    // Storage write, the entry becomes visible at the head on the next cycle
    always_ff @(posedge clk)
    begin
        if (push)
        begin
            mem[wr_ptr] <= push_frame;
        end
    end

    // Pointers wrap naturally since the depth is a power of two
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Occupancy, a simultaneous push and pop leaves it unchanged
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            count <= '0;
        end
        else if (push && !pop)
        begin
            count <= count + 1'b1;
        end
        else if (pop && !push)
        begin
            count <= count - 1'b1;
        end
    end

    // Every freed slot goes back to the source as one credit
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            credit <= 1'b0;
        end
        else
        begin
            credit <= pop;
        end
    end

    assign head_frame = mem[rd_ptr];  // Fall-through read
    assign empty      = (count == '0);

endmodule

`default_nettype wire

//--- hdl/i2s_serializer.sv
/*
 * I2S serializer, the consumer: clock divider for mclk, bclk and lrclk,
 * frame load with underrun fill, 64 bit slot shift register and the
 * FSM that sequences load and shift
 */
`timescale 1ns/1ps
`default_nettype none

module i2s_serializer
(
    input  logic                      clk,
    input  logic                      reset,
    input  audio_pkg::stereo_frame_t  head_frame,
    input  logic                      empty,
    output logic                      pop,       // Same cycle as the load
    output logic                      underrun,  // Pulses when a silent frame had to be inserted
    output logic                      mclk,
    output logic                      bclk,
    output logic                      lrclk,     // Low for the left slot, high for the right slot
    output logic                      sdata
);

    audio_pkg::clk_div_t          clk_div;
    audio_pkg::serializer_state_t state;
    audio_pkg::frame_shift_t      shift_reg;  // Left slot in the upper half, right slot below
    audio_pkg::stereo_frame_t     load_frame;

    logic pre_load;  // Cycle before the divider reaches all ones
    logic bit_end;   // Last cycle of a bclk period, bclk falls right after it

    // Free-running divider, every output clock is a plain register bit
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            clk_div <= '0;
        end
        else
        begin
            clk_div <= clk_div + 1'b1;
        end
    end

    assign mclk  = clk_div[audio_pkg::MCLK_BIT];
    assign bclk  = clk_div[audio_pkg::BCLK_BIT];
    assign lrclk = clk_div[audio_pkg::LRCLK_BIT];

    assign pre_load = (clk_div == {{(audio_pkg::DIV_W - 1){1'b1}}, 1'b0});
    assign bit_end  = &clk_div[audio_pkg::BCLK_BIT:0];

    // ST_LOAD lines up with the all-ones divider value, the cycle before lrclk falls
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state <= audio_pkg::ST_IDLE;
        end
        else
        begin
            case (state)
                audio_pkg::ST_IDLE:  if (pre_load) state <= audio_pkg::ST_LOAD;
                audio_pkg::ST_LOAD:  state <= audio_pkg::ST_SHIFT;  // Load lasts one cycle
                audio_pkg::ST_SHIFT: if (pre_load) state <= audio_pkg::ST_LOAD;
                default:             state <= audio_pkg::ST_IDLE;
            endcase
        end
    end

    // Take the head frame, or silence when the FIFO ran dry
    assign load_frame = empty ? '0 : head_frame;
    assign pop        = (state == audio_pkg::ST_LOAD) && !empty;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            underrun <= 1'b0;
        end
        else
        begin
            underrun <= (state == audio_pkg::ST_LOAD) && empty;  // High in the first cycle of the frame
        end
    end

    // Samples sit left justified in their 32 bit slots
    always_ff @(posedge clk)
    begin
        if (state == audio_pkg::ST_LOAD)
        begin
            shift_reg <= {load_frame.left,  {audio_pkg::SLOT_PAD_W{1'b0}},
                          load_frame.right, {audio_pkg::SLOT_PAD_W{1'b0}}};
        end
        else if (state == audio_pkg::ST_SHIFT && bit_end)
        begin
            shift_reg <= shift_reg << 1;
        end
    end

    /*
     * sdata trails the shift register by one bit period. The load happens a
     * full bclk period before the MSB leaves, which gives the I2S one bit
     * delay after each lrclk edge
     */
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            sdata <= 1'b0;
        end
        else if (state == audio_pkg::ST_LOAD)
        begin
            sdata <= 1'b0;  // Last bit of the right slot is always padding
        end
        else if (state == audio_pkg::ST_SHIFT && bit_end)
        begin
            sdata <= shift_reg[audio_pkg::FRAME_BITS-1];  // Changes as bclk falls
        end
    end

endmodule

`default_nettype wire

//--- hdl/audio_out_top.sv
/*
 * Top level of the I2S output path: volume scaler into frame FIFO into
 * serializer, with the credit return and the I2S pins brought out
 */
`timescale 1ns/1ps
`default_nettype none

module audio_out_top
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_valid,  // Source may only assert this while it holds a credit
    input  audio_pkg::audio_in_t  in_frame,
    output logic                  credit,    // One pulse per frame the serializer consumed
    output logic                  underrun,
    output logic                  mclk,
    output logic                  bclk,
    output logic                  lrclk,
    output logic                  sdata
);

    logic                     push;
    audio_pkg::stereo_frame_t push_frame;  // Scaled frame on its way into the FIFO
    audio_pkg::stereo_frame_t head_frame;
    logic                     empty;
    logic                     pop;

    volume_scaler scaler_i
    (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_frame   (in_frame),
        .push       (push),
        .push_frame (push_frame)
    );

    sample_fifo fifo_i
    (
        .clk        (clk),
        .reset      (reset),
        .push       (push),
        .push_frame (push_frame),
        .pop        (pop),
        .head_frame (head_frame),
        .empty      (empty),
        .credit     (credit)       // Goes straight back to the source
    );

    i2s_serializer serializer_i
    (
        .clk        (clk),
        .reset      (reset),
        .head_frame (head_frame),
        .empty      (empty),
        .pop        (pop),
        .underrun   (underrun),
        .mclk       (mclk),
        .bclk       (bclk),
        .lrclk      (lrclk),
        .sdata      (sdata)
    );

endmodule

`default_nettype wire

//--- sim/tb_clock_gen.sv
/*
 * Testbench clock and reset source with a 4 ns clk and reset held
 * high for the first 10 cycles
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen
(
    output logic clk,
    output logic reset
);

    localparam int HALF_PERIOD_NS = 2;   // 250 MHz simulation clock
    localparam int RESET_CYCLES   = 10;

    initial
    begin
        clk = 1'b0;
        forever #HALF_PERIOD_NS clk = ~clk;
    end

    // Release lands 1 ns after an edge like every other stimulus
    initial
    begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

`default_nettype wire

//--- sim/audio_out_props.sv
/*
 * Protocol assertions bound into audio_out_top that cover FIFO push and
 * pop legality, credit pulse shape and lrclk phasing
 */
`timescale 1ns/1ps
`default_nettype none

module audio_out_props
(
    input logic clk,
    input logic reset,
    input logic push,
    input logic pop,
    input logic credit,
    input logic bclk,
    input logic lrclk
);

    audio_pkg::fifo_count_t occupancy;  // Shadow of the FIFO fill level
    int failures = 0;                   // Count of failed assertions

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            occupancy <= '0;
        end
        else if (push && !pop)
        begin
            occupancy <= occupancy + 1'b1;
        end
        else if (pop && !push)
        begin
            occupancy <= occupancy - 1'b1;
        end
    end

    push_not_full: assert property (@(posedge clk) disable iff (reset)
        push |-> occupancy != audio_pkg::fifo_count_t'(audio_pkg::FIFO_DEPTH))
        else begin $error("FIFO received a push while full"); failures++; end

    // A pop needs a frame that was pushed and not yet taken
    pop_not_empty: assert property (@(posedge clk) disable iff (reset)
        pop |-> occupancy != '0)
        else begin $error("Pop issued while the FIFO was empty"); failures++; end

    // Each credit is one cycle wide and answers the pop just before it
    credit_after_pop: assert property (@(posedge clk) disable iff (reset)
        credit |-> $past(pop) && !$past(credit))
        else begin $error("Credit pulse without a preceding pop"); failures++; end

    lrclk_on_bclk_fall: assert property (@(posedge clk) disable iff (reset)
        (lrclk != $past(lrclk)) |-> (!bclk && $past(bclk)))
        else begin $error("lrclk moved away from a bclk falling edge"); failures++; end

endmodule

bind audio_out_top audio_out_props props_i
(
    .clk    (clk),
    .reset  (reset),
    .push   (push),
    .pop    (pop),
    .credit (credit),
    .bclk   (bclk),
    .lrclk  (lrclk)
);

`default_nettype wire

//--- sim/audio_out_tb.sv
/*
 * Testbench for the I2S output path with a golden file frame source under
 * credits, an sdata decoder with clock ratio checks and end of run checks
 */
`timescale 1ns/1ps
`default_nettype none

module audio_out_tb;

    localparam int FRAME_COUNT    = 22;  // Frame lines in the golden file
    localparam int WORDS_PER_LINE = 5;   // Volume, left, right, expected left, expected right
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int DRAIN_EVERY    = 8;   // Every eighth frame waits for an empty FIFO first
    localparam int MCLK_PER_BCLK  = 4;   // mclk runs four times as fast as bclk
    localparam int BCLK_PER_LRCLK = 64;  // Two 32 bit slots per lrclk period

    logic                 clk;
    logic                 reset;
    logic                 in_valid;
    audio_pkg::audio_in_t in_frame;
    logic                 credit;
    logic                 underrun;
    logic                 mclk;
    logic                 bclk;
    logic                 lrclk;
    logic                 sdata;

    logic [15:0] golden_mem [FRAME_COUNT*WORDS_PER_LINE];

    int sent;             // Cycles with in_valid high
    int returned;         // Credit pulses seen
    int matched;          // Golden frames found on sdata
    int underrun_frames;  // Silent frames flagged by underrun

    logic mclk_q;                   // Previous samples for edge detection
    logic bclk_q;
    logic lrclk_q;
    logic frame_active;             // A loaded frame is being decoded
    logic frame_underrun;           // Underrun flag of the frame being decoded
    logic bclk_seen;                // First bclk rise after reset has passed
    int   mclk_rises;
    int   bclk_rises;
    int   slot_pos;                 // bclk rises since the last lrclk edge
    audio_pkg::sample_t left_bits;
    audio_pkg::sample_t right_bits;

    tb_clock_gen clock_gen_i (.clk(clk), .reset(reset));

    audio_out_top dut_i
    (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .in_frame (in_frame),
        .credit   (credit),
        .underrun (underrun),
        .mclk     (mclk),
        .bclk     (bclk),
        .lrclk    (lrclk),
        .sdata    (sdata)
    );

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_sample(input string name, input audio_pkg::sample_t got,
                                input audio_pkg::sample_t expected);
        if (got !== expected)
            stop_with_failure($sformatf("Error: %s got 0x%04h expected 0x%04h",
                                        name, got, expected));
    endtask

    task automatic check_count(input string name, input int got, input int expected);
        if (got != expected)
            stop_with_failure($sformatf("Error: %s got 0x%0h expected 0x%0h",
                                        name, got, expected));
    endtask

    task automatic hold_until_reset_released();
        int cycles = 0;
        while (reset !== 1'b0)
        begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > TIMEOUT_CYCLES) stop_with_failure("Reset was never released");
        end
    endtask

    // Source side of the credit rule stalls while it holds no credit
    task automatic acquire_credit();
        int cycles = 0;
        while (audio_pkg::FIFO_DEPTH - sent + returned == 0)
        begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > TIMEOUT_CYCLES) stop_with_failure("Timed out waiting for a credit");
        end
    endtask

    // All credits back means the FIFO and the scaler hold nothing
    task automatic drain_fifo();
        int cycles = 0;
        int seen;
        seen = returned;
        while (returned != sent)
        begin
            @(posedge clk);
            #1;
            cycles = (returned != seen) ? 0 : cycles + 1;  // Each returned credit restarts the limit
            seen   = returned;
            if (cycles > TIMEOUT_CYCLES)
                stop_with_failure("Timed out waiting for the FIFO to drain");
        end
    endtask

    task automatic expect_next_frame();
        int cycles = 0;
        int seen;
        seen = matched;
        while (matched == seen)
        begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > TIMEOUT_CYCLES)
                stop_with_failure($sformatf("Timed out waiting for frame %0d on sdata", seen));
        end
    endtask

    task automatic send_frame(input int index);
        acquire_credit();
        in_frame.volume = golden_mem[index*WORDS_PER_LINE][audio_pkg::VOL_W-1:0];
        in_frame.left   = golden_mem[index*WORDS_PER_LINE + 1];
        in_frame.right  = golden_mem[index*WORDS_PER_LINE + 2];
        in_valid        = 1'b1;
        sent++;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    // A silent frame takes no golden entry while any other frame takes the next one
    task automatic score_frame();
        if (frame_underrun)
        begin
            check_sample("left sample of underrun frame", left_bits, '0);
            check_sample("right sample of underrun frame", right_bits, '0);
            underrun_frames++;
        end
        else
        begin
            check_sample("left sample", left_bits, golden_mem[matched*WORDS_PER_LINE + 3]);
            check_sample("right sample", right_bits, golden_mem[matched*WORDS_PER_LINE + 4]);
            matched++;
        end
    endtask

    // Monitor samples the DUT pins at each clock edge and decodes the I2S stream
    always @(posedge clk)
    begin
        if (!reset)
        begin
            if (credit) returned++;
            if (returned > sent)
                stop_with_failure("More credits came back than frames were sent");
            if (mclk && !mclk_q) mclk_rises++;
            if (lrclk != lrclk_q)
            begin
                if (bclk) stop_with_failure("lrclk changed while bclk was high");
                slot_pos = 0;  // New channel slot
                if (!lrclk)
                begin
                    if (frame_active)
                    begin
                        check_count("bclk periods per lrclk period", bclk_rises, BCLK_PER_LRCLK);
                        score_frame();
                    end
                    frame_active   = 1'b1;
                    frame_underrun = underrun;  // Pulses in the first cycle of the frame
                    bclk_rises     = 0;
                end
            end
            if (bclk && !bclk_q)
            begin
                if (bclk_seen)
                    check_count("mclk periods per bclk period", mclk_rises, MCLK_PER_BCLK);
                mclk_rises = 0;
                bclk_seen  = 1'b1;
                bclk_rises++;
                // Slot bit 0 is the I2S delay bit and the sample follows MSB first
                if (slot_pos >= 1 && slot_pos <= audio_pkg::SAMPLE_W)
                begin
                    if (lrclk)
                        right_bits = {right_bits[audio_pkg::SAMPLE_W-2:0], sdata};
                    else
                        left_bits = {left_bits[audio_pkg::SAMPLE_W-2:0], sdata};
                end
                slot_pos++;
            end
        end
        mclk_q  = mclk;
        bclk_q  = bclk;
        lrclk_q = lrclk;
    end

    initial
    begin
        int gap;
        in_valid        = 1'b0;
        in_frame        = '0;
        sent            = 0;
        returned        = 0;
        matched         = 0;
        underrun_frames = 0;
        mclk_q          = 1'b0;
        bclk_q          = 1'b0;
        lrclk_q         = 1'b0;
        frame_active    = 1'b0;
        frame_underrun  = 1'b0;
        bclk_seen       = 1'b0;
        mclk_rises      = 0;
        bclk_rises      = 0;
        slot_pos        = 0;
        left_bits       = '0;
        right_bits      = '0;
        $readmemh("sim/audio_golden.txt", golden_mem);
        void'($urandom(88301));
        hold_until_reset_released();
        for (int i = 0; i < FRAME_COUNT; i++)
        begin
            if (i % DRAIN_EVERY == DRAIN_EVERY - 1)
            begin
                drain_fifo();
                gap = 600;  // Longer than a frame so that a load point finds the FIFO empty
            end
            else
                gap = $urandom_range(0, 600);
            repeat (gap)
            begin
                @(posedge clk);
                #1;
            end
            send_frame(i);
        end
        while (matched < FRAME_COUNT) expect_next_frame();
        check_count("credits returned", returned, sent);
        if (underrun_frames == 0)
            stop_with_failure("No underrun frame was seen during the pauses");
        if (dut_i.props_i.failures == 0)
        begin
            $display("Test OK");
            $finish;
        end
        else
            stop_with_failure("A protocol assertion failed during the run");
    end

endmodule

`default_nettype wire

//--- sim/audio_golden.txt
// Each line holds volume code, left in, right in, expected left out and expected right out
// Values are hex and code 7 mutes both channels
0 1234 EDCC 1234 EDCC
1 7FFF 8000 3FFF C000
2 4000 C000 1000 F000
3 0F0F F0F1 01E1 FE1E
4 5A5A A5A5 05A5 FA5A
5 7FFF 8001 03FF FC00
6 2000 DFFF 0080 FF7F
7 7FFF 8000 0000 0000
0 0001 FFFF 0001 FFFF
1 0003 FFFD 0001 FFFE
2 1000 F000 0400 FC00
3 0008 FFF8 0001 FFFF
4 00FF FF00 000F FFF0
5 3FE0 C020 01FF FE01
6 7FC0 8040 01FF FE01
7 1234 4321 0000 0000
0 8000 7FFF 8000 7FFF
1 8000 0000 C000 0000
2 0007 FFF9 0001 FFFE
3 7654 89AB 0ECA F135
4 0010 FFEF 0001 FFFE
5 6000 A000 0300 FD00

//--- sim.f
hdl/audio_pkg.sv
hdl/volume_scaler.sv
hdl/sample_fifo.sv
hdl/i2s_serializer.sv
hdl/audio_out_top.sv
sim/tb_clock_gen.sv
sim/audio_out_props.sv
sim/audio_out_tb.sv

//--- Makefile
# Verilator build and run for the I2S output path testbench
# The exit status of run is the pass or fail result

TOP = audio_out_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f sim.f -o V$(TOP)

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
